// ==== build.f ====
+incdir+include
design/alut_pkg.sv
design/alut_mem_if.sv
design/alut_mem.sv
design/alut_age_checker.sv
design/alut_addr_checker.sv
design/alut_wb_regs.sv
design/alut_top.sv
dv/alut_clk_gen.sv
dv/alut_tb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = alut_tb
FILELIST = build.f

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "^PASS: all tests$$"

clean:
	rm -rf obj_dir

// ==== dv/alut_tb.sv ====
`default_nettype none

`include "alut_macros.svh"

module alut_tb
   import alut_pkg::*;
();

   localparam int          DRIVE_DLY = 10;                  // after the rising edge
   localparam logic [47:0] SW_MAC    = 48'h02_00_5e_10_20_30;

   logic        pclk23, n_p_reset23;
   logic        wb_cyc, wb_stb, wb_we, wb_ack;
   logic [3:0]  wb_adr, wb_sel;
   logic [31:0] wb_dat_w, wb_dat_r;

   int          errors      = 0;
   int          checks      = 0;
   int          cycles      = 0;
   int          cycle_limit = 0;
   logic [31:0] rand_state  = 32'd58;                       // lcg seed

   // stimulus table, one entry per row in every queue
   string       row_name[$];
   logic [47:0] row_d[$];
   logic [47:0] row_s[$];
   logic [1:0]  row_sp[$];
   int          row_wait[$];                                // idle cycles before the check
   logic [31:0] row_age[$];
   logic        row_calc[$];                                // expected from the model
   port_mask_t  row_dport[$];
   logic        row_reused[$];

   // reference table, address and port per hash slot
   logic [47:0] ref_addr  [`ALUT_DEPTH];
   logic [1:0]  ref_port  [`ALUT_DEPTH];
   logic        ref_valid [`ALUT_DEPTH];

   alut_clk_gen u_clk_gen (.pclk23(pclk23), .n_p_reset23(n_p_reset23));

   alut_top UUT (
      .pclk23(pclk23), .n_p_reset23(n_p_reset23),
      .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
      .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_sel(wb_sel),
      .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
   );

   function automatic logic [31:0] next_rand();
      rand_state = rand_state * 32'd1664525 + 32'd1013904223;
      return rand_state;
   endfunction

   function automatic logic [47:0] rand_addr();
      logic [31:0] hi;
      logic [31:0] lo;
      hi = next_rand();
      lo = next_rand();
      return {hi[15:9], 1'b0, hi[7:0], lo};                 // keep it unicast
   endfunction

   function automatic logic [7:0] hash_of(input logic [47:0] a);
      logic [7:0] h;
      h = 8'h00;
      for (int k = 0; k < 6; k++)
         h ^= a[8*k +: 8];                                  // fold byte by byte
      return h;
   endfunction

   // ------------------------------------------------------------
   // wishbone master
   // ------------------------------------------------------------
   task automatic write_reg(input logic [3:0] adr, input logic [31:0] dat);
      @(posedge pclk23);
      #DRIVE_DLY;
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = 1'b1;
      wb_adr   = adr;
      wb_dat_w = dat;
      wb_sel   = 4'hf;
      do
      begin
         @(posedge pclk23);
         #DRIVE_DLY;
      end
      while (!wb_ack);
      wb_cyc = 1'b0;                                        // single access, release
      wb_stb = 1'b0;
      wb_we  = 1'b0;
   endtask

   task automatic read_reg(input logic [3:0] adr, output logic [31:0] dat);
      @(posedge pclk23);
      #DRIVE_DLY;
      wb_cyc = 1'b1;
      wb_stb = 1'b1;
      wb_we  = 1'b0;
      wb_adr = adr;
      wb_sel = 4'hf;
      do
      begin
         @(posedge pclk23);
         #DRIVE_DLY;
      end
      while (!wb_ack);
      dat    = wb_dat_r;                                    // registered with ack
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
   endtask

   // program the frame, start the check and poll until idle
   task automatic run_check(input logic [47:0] d, input logic [47:0] s, input logic [1:0] sp,
                            output port_mask_t dport, output logic reuse);
      logic [31:0] status;
      write_reg(`ALUT_REG_DADDR_LO, d[31:0]);
      write_reg(`ALUT_REG_DADDR_HI, {16'h0, d[47:32]});
      write_reg(`ALUT_REG_SADDR_LO, s[31:0]);
      write_reg(`ALUT_REG_SADDR_HI, {16'h0, s[47:32]});
      write_reg(`ALUT_REG_SPORT, {30'h0, sp});
      write_reg(`ALUT_REG_CMD, {30'h0, `ALUT_CMD_CHECK});
      do
         read_reg(`ALUT_REG_STATUS, status);
      while (status[0]);                                    // active bit
      dport = status[5:1];
      reuse = status[6];
   endtask

   task automatic check_eq(input string name, input logic [47:0] exp, input logic [47:0] act);
      checks++;
      assert (act === exp)
      else
      begin
         errors++;
         $display("Fail %s: expected %0h, actual %0h", name, exp, act);
      end
   endtask

   // ------------------------------------------------------------
   // reference model, lookup first, then learn the source
   // ------------------------------------------------------------
   task automatic predict(input logic [47:0] d, input logic [47:0] s, input logic [1:0] sp,
                          output port_mask_t dport, output logic reuse,
                          output logic [47:0] inv_a, output logic [1:0] inv_p);
      logic [7:0] hd;
      logic [7:0] hs;
      port_mask_t src_bit;
      src_bit     = 5'b0;
      src_bit[sp] = 1'b1;
      reuse       = 1'b0;
      inv_a       = 48'h0;
      inv_p       = 2'd0;
      hd          = hash_of(d);
      hs          = hash_of(s);
      if (d == SW_MAC)
         dport = 5'b1_0000;                                 // no learning on this path
      else
      begin
         if (ref_valid[hd] && ref_addr[hd] == d)
         begin
            dport               = 5'b0;
            dport[ref_port[hd]] = 1'b1;
            dport               = dport & ~src_bit;
         end
         else
            dport = 5'b0_1111 & ~src_bit;                   // flood
         if (ref_valid[hs] && ref_addr[hs] != s)
         begin
            reuse = 1'b1;
            inv_a = ref_addr[hs];
            inv_p = ref_port[hs];
         end
         ref_valid[hs] = 1'b1;
         ref_addr[hs]  = s;
         ref_port[hs]  = sp;
      end
   endtask

   task automatic add_row(input string name, input logic [47:0] d, input logic [47:0] s,
                          input logic [1:0] sp, input int wait_cyc, input logic [31:0] age,
                          input logic calc, input port_mask_t dport, input logic reuse);
      row_name.push_back(name);
      row_d.push_back(d);
      row_s.push_back(s);
      row_sp.push_back(sp);
      row_wait.push_back(wait_cyc);
      row_age.push_back(age);
      row_calc.push_back(calc);
      row_dport.push_back(dport);
      row_reused.push_back(reuse);
   endtask

   task automatic build_table();
      logic [47:0] learned;
      logic [1:0]  p;
      //      name          d_addr                 s_addr                 port  wait age
      add_row("mac_hit",    SW_MAC,                48'h02_00_00_00_00_10, 2'd0, 0, `ALUT_AGE_DEFAULT,
              1'b0, 5'b1_0000, 1'b0);
      add_row("flood_p0",   48'h02_00_00_00_01_00, 48'h02_00_00_00_00_10, 2'd0, 0, `ALUT_AGE_DEFAULT,
              1'b0, 5'b0_1110, 1'b0);
      add_row("flood_p1",   48'h02_00_00_00_01_01, 48'h02_00_00_00_00_11, 2'd1, 0, `ALUT_AGE_DEFAULT,
              1'b0, 5'b0_1101, 1'b0);
      add_row("flood_p2",   48'h02_00_00_00_01_02, 48'h02_00_00_00_00_12, 2'd2, 0, `ALUT_AGE_DEFAULT,
              1'b0, 5'b0_1011, 1'b0);
      add_row("flood_p3",   48'h02_00_00_00_01_03, 48'h02_00_00_00_00_13, 2'd3, 0, `ALUT_AGE_DEFAULT,
              1'b0, 5'b0_0111, 1'b0);
      add_row("learn_a",    48'h02_00_00_00_01_04, 48'h02_11_22_33_44_55, 2'd2, 0, `ALUT_AGE_DEFAULT,
              1'b1, 5'b0, 1'b0);
      add_row("hit_a",      48'h02_11_22_33_44_55, 48'h02_66_77_88_99_aa, 2'd0, 0, `ALUT_AGE_DEFAULT,
              1'b1, 5'b0, 1'b0);
      add_row("hit_a_p3",   48'h02_11_22_33_44_55, 48'h02_00_00_00_00_13, 2'd3, 0, `ALUT_AGE_DEFAULT,
              1'b1, 5'b0, 1'b0);
      // 12_34 and 34_12 fold to the same slot
      add_row("learn_x",    48'h02_00_00_00_01_05, 48'h02_00_00_00_12_34, 2'd1, 0, `ALUT_AGE_DEFAULT,
              1'b1, 5'b0, 1'b0);
      add_row("learn_y",    48'h02_00_00_00_01_06, 48'h02_00_00_00_34_12, 2'd3, 0, `ALUT_AGE_DEFAULT,
              1'b1, 5'b0, 1'b0);
      add_row("learn_c",    48'h02_00_00_00_01_07, 48'h02_00_00_00_00_40, 2'd2, 0, `ALUT_AGE_DEFAULT,
              1'b1, 5'b0, 1'b0);
      add_row("stale_c",    48'h02_00_00_00_00_40, 48'h02_00_00_00_00_50, 2'd0, 20, 32'd2,
              1'b0, 5'b0_1110, 1'b0);                       // aged out, floods
      add_row("fresh_c",    48'h02_00_00_00_00_40, 48'h02_00_00_00_00_50, 2'd0, 0, `ALUT_AGE_DEFAULT,
              1'b0, 5'b0_0100, 1'b0);
      // random pairs, learn then look up from the next port
      for (int k = 0; k < 4; k++)
      begin
         learned = rand_addr();
         p       = 2'(k);
         add_row($sformatf("rnd_learn_%0d", k), rand_addr(), learned, p, 0, `ALUT_AGE_DEFAULT,
                 1'b1, 5'b0, 1'b0);
         add_row($sformatf("rnd_hit_%0d", k), learned, rand_addr(), p + 2'd1, 0,
                 `ALUT_AGE_DEFAULT, 1'b1, 5'b0, 1'b0);
      end
   endtask

   // ------------------------------------------------------------
   // run limit
   // ------------------------------------------------------------
   always @(posedge pclk23)
   begin
      cycles++;
      if (cycle_limit > 0 && cycles >= cycle_limit)
      begin
         $display("timeout: check never finished after %0d cycles", cycles);
         $display("FAIL: see errors above");
         $finish;
      end
   end

   initial
   begin
      logic [31:0] rdata;
      port_mask_t  got_dport;
      logic        got_reused;
      port_mask_t  mdl_dport;
      logic        mdl_reused;
      port_mask_t  exp_dport;
      logic        exp_reused;
      logic [47:0] inv_a;
      logic [1:0]  inv_p;
      wb_cyc   = 1'b0;
      wb_stb   = 1'b0;
      wb_we    = 1'b0;
      wb_adr   = 4'h0;
      wb_dat_w = 32'h0;
      wb_sel   = 4'h0;
      foreach (ref_valid[j])
         ref_valid[j] = 1'b0;
      build_table();
      foreach (row_wait[i])
         cycle_limit += 40 + row_wait[i];                   // worst case per check
      cycle_limit = cycle_limit * 2;
      @(posedge n_p_reset23);

      read_reg(`ALUT_REG_STATUS, rdata);                    // idle, flood mask, no reuse
      check_eq("reset_status", 48'h1e, 48'(rdata));
      write_reg(`ALUT_REG_MAC_LO, SW_MAC[31:0]);
      write_reg(`ALUT_REG_MAC_HI, {16'h0, SW_MAC[47:32]});

      for (int i = 0; i < row_name.size(); i++)
      begin
         write_reg(`ALUT_REG_AGE_LIMIT, row_age[i]);
         repeat (row_wait[i]) @(posedge pclk23);
         predict(row_d[i], row_s[i], row_sp[i], mdl_dport, mdl_reused, inv_a, inv_p);
         run_check(row_d[i], row_s[i], row_sp[i], got_dport, got_reused);
         exp_dport  = row_calc[i] ? mdl_dport  : row_dport[i];
         exp_reused = row_calc[i] ? mdl_reused : row_reused[i];
         check_eq({row_name[i], " d_port"}, 48'(exp_dport), 48'(got_dport));
         check_eq({row_name[i], " reused"}, 48'(exp_reused), 48'(got_reused));
         if (exp_reused)
         begin
            read_reg(`ALUT_REG_INV_LO, rdata);
            check_eq({row_name[i], " inv_lo"}, 48'(inv_a[31:0]), 48'(rdata));
            read_reg(`ALUT_REG_INV_HI, rdata);              // port in 17..16
            check_eq({row_name[i], " inv_hi"}, 48'({14'h0, inv_p, inv_a[47:32]}), 48'(rdata));
            read_reg(`ALUT_REG_STATUS, rdata);
            check_eq({row_name[i], " reused_clr"}, 48'h0, 48'(rdata[6]));
         end
      end

      $display("checks: %0d  errors: %0d", checks, errors);
      if (errors == 0)
         $display("PASS: all tests");
      else
         $display("FAIL: see errors above");
      $finish;
   end

endmodule

`default_nettype wire

// ==== dv/alut_clk_gen.sv ====
`default_nettype none

module alut_clk_gen
#(
   parameter int PERIOD    = 100,   // time units per clock
   parameter int RST_CYCLES = 3
)
(
   output logic pclk23,
   output logic n_p_reset23
);

   initial
   begin
      pclk23 = 1'b0;
      forever #(PERIOD / 2) pclk23 = ~pclk23;
   end

   // release a little after the edge, like the bus stimulus
   initial
   begin
      n_p_reset23 = 1'b0;
      repeat (RST_CYCLES) @(posedge pclk23);
      #(PERIOD / 10);
      n_p_reset23 = 1'b1;
   end

endmodule

`default_nettype wire

// ==== design/alut_top.sv ====
`default_nettype none

module alut_top
   import alut_pkg::*;
(
   input  logic        pclk23,
   input  logic        n_p_reset23,
   input  logic        wb_cyc,
   input  logic        wb_stb,
   input  logic        wb_we,
   input  logic [3:0]  wb_adr,
   input  logic [31:0] wb_dat_w,
   input  logic [3:0]  wb_sel,
   output logic [31:0] wb_dat_r,
   output logic        wb_ack
);

   // register slave to checker
   logic [47:0] mac_addr;
   logic [47:0] d_addr;
   logic [47:0] s_addr;
   logic [1:0]  s_port;
   logic [31:0] age_limit;
   logic [1:0]  command;
   logic        clear_reused;

   // checker results back to status
   port_mask_t  d_port;
   logic        add_check_active;
   logic        reused;
   logic [47:0] lst_inv_addr;
   logic [1:0]  lst_inv_port;

   // checker and age checker handshake
   logic [31:0] curr_time;
   logic        check_age;
   logic [31:0] last_accessed;
   logic        age_confirmed;
   logic        age_ok;

   alut_mem_if mem ();   // single table port, no arbitration

   alut_wb_regs u_wb_regs (.*);

   alut_addr_checker u_addr_checker (.*);

   alut_age_checker u_age_checker (.*);

   alut_mem u_mem (.*);

endmodule

`default_nettype wire

// ==== design/alut_wb_regs.sv ====
`default_nettype none

`include "alut_macros.svh"

module alut_wb_regs
   import alut_pkg::*;
(
   input  logic        pclk23,
   input  logic        n_p_reset23,
   input  logic        wb_cyc,
   input  logic        wb_stb,
   input  logic        wb_we,
   input  logic [3:0]  wb_adr,            // word offset
   input  logic [31:0] wb_dat_w,
   input  logic [3:0]  wb_sel,
   output logic [31:0] wb_dat_r,
   output logic        wb_ack,
   input  port_mask_t  d_port,
   input  logic        add_check_active,
   input  logic        reused,
   input  logic [47:0] lst_inv_addr,
   input  logic [1:0]  lst_inv_port,
   output logic [47:0] mac_addr,
   output logic [47:0] d_addr,
   output logic [47:0] s_addr,
   output logic [1:0]  s_port,
   output logic [31:0] age_limit,
   output logic [1:0]  command,           // one-cycle check code
   output logic        clear_reused
);

   logic req;
   logic wr_req;
   logic rd_req;

   function automatic logic [31:0] merge32(input logic [31:0] old_val,
                                           input logic [31:0] new_val,
                                           input logic [3:0]  sel);
      logic [31:0] res;
      res = old_val;
      for (int i = 0; i < 4; i++)
         if (sel[i])
            res[8*i +: 8] = new_val[8*i +: 8];
      return res;
   endfunction

   // upper halves of the addresses only take byte lanes 0 and 1
   function automatic logic [15:0] merge16(input logic [15:0] old_val,
                                           input logic [31:0] new_val,
                                           input logic [3:0]  sel);
      logic [31:0] full;
      full = merge32({16'h0, old_val}, new_val, sel);
      return full[15:0];
   endfunction

   assign req    = wb_cyc && wb_stb && !wb_ack;   // ack ends the access
   assign wr_req = req && wb_we;
   assign rd_req = req && !wb_we;

   // ------------------------------------------------------------
   // handshake and pulses
   // ------------------------------------------------------------
   always_ff @(posedge pclk23 or negedge n_p_reset23)
   begin
      if (!n_p_reset23)
      begin
         wb_ack       <= 1'b0;
         command      <= 2'b00;
         clear_reused <= 1'b0;
      end
      else
      begin
         wb_ack       <= req;                     // no wait states
         command      <= (wr_req && wb_adr == `ALUT_REG_CMD && wb_sel[0] &&
                          !add_check_active) ? wb_dat_w[1:0] : 2'b00;
         clear_reused <= rd_req && (wb_adr == `ALUT_REG_STATUS);
      end
   end

   // ------------------------------------------------------------
   // configuration and frame registers
   // ------------------------------------------------------------
   always_ff @(posedge pclk23 or negedge n_p_reset23)
   begin
      if (!n_p_reset23)
      begin
         mac_addr  <= '0;
         d_addr    <= '0;
         s_addr    <= '0;
         s_port    <= '0;
         age_limit <= `ALUT_AGE_DEFAULT;
      end
      else if (wr_req)
      begin
         case (wb_adr)
            `ALUT_REG_MAC_LO:    mac_addr[31:0]  <= merge32(mac_addr[31:0], wb_dat_w, wb_sel);
            `ALUT_REG_MAC_HI:    mac_addr[47:32] <= merge16(mac_addr[47:32], wb_dat_w, wb_sel);
            `ALUT_REG_DADDR_LO:  d_addr[31:0]    <= merge32(d_addr[31:0], wb_dat_w, wb_sel);
            `ALUT_REG_DADDR_HI:  d_addr[47:32]   <= merge16(d_addr[47:32], wb_dat_w, wb_sel);
            `ALUT_REG_SADDR_LO:  s_addr[31:0]    <= merge32(s_addr[31:0], wb_dat_w, wb_sel);
            `ALUT_REG_SADDR_HI:  s_addr[47:32]   <= merge16(s_addr[47:32], wb_dat_w, wb_sel);
            `ALUT_REG_SPORT:     if (wb_sel[0]) s_port <= wb_dat_w[1:0];
            `ALUT_REG_AGE_LIMIT: age_limit       <= merge32(age_limit, wb_dat_w, wb_sel);
            default: ;                            // CMD handled above, rest read only
         endcase
      end
   end

   // read data, sampled with the request
   always_ff @(posedge pclk23)
   begin
      if (rd_req)
      begin
         case (wb_adr)
            `ALUT_REG_MAC_LO:    wb_dat_r <= mac_addr[31:0];
            `ALUT_REG_MAC_HI:    wb_dat_r <= {16'h0, mac_addr[47:32]};
            `ALUT_REG_DADDR_LO:  wb_dat_r <= d_addr[31:0];
            `ALUT_REG_DADDR_HI:  wb_dat_r <= {16'h0, d_addr[47:32]};
            `ALUT_REG_SADDR_LO:  wb_dat_r <= s_addr[31:0];
            `ALUT_REG_SADDR_HI:  wb_dat_r <= {16'h0, s_addr[47:32]};
            `ALUT_REG_SPORT:     wb_dat_r <= {30'h0, s_port};
            `ALUT_REG_AGE_LIMIT: wb_dat_r <= age_limit;
            `ALUT_REG_STATUS:    wb_dat_r <= {25'h0, reused, d_port, add_check_active};
            `ALUT_REG_INV_LO:    wb_dat_r <= lst_inv_addr[31:0];
            `ALUT_REG_INV_HI:    wb_dat_r <= {14'h0, lst_inv_port, lst_inv_addr[47:32]};
            default:             wb_dat_r <= 32'h0;
         endcase
      end
   end

   // slave only answers a live request
   a_ack_needs_req: assert property (@(posedge pclk23) disable iff (!n_p_reset23)
      $rose(wb_ack) |-> $past(wb_cyc && wb_stb));

endmodule

`default_nettype wire

// ==== design/alut_addr_checker.sv ====
`default_nettype none

`include "alut_macros.svh"

module alut_addr_checker
   import alut_pkg::*;
(
   input  logic        pclk23,
   input  logic        n_p_reset23,
   input  logic [1:0]  command,         // check code for one cycle
   input  logic [47:0] mac_addr,        // switch address
   input  logic [47:0] d_addr,          // frame destination
   input  logic [47:0] s_addr,          // frame source, learned
   input  logic [1:0]  s_port,
   input  logic [31:0] curr_time,
   input  logic        age_confirmed,
   input  logic        age_ok,
   input  logic        clear_reused,    // status read
   alut_mem_if.chk     mem,
   output port_mask_t  d_port,
   output logic        add_check_active,
   output logic        check_age,
   output logic [31:0] last_accessed,
   output logic        reused,
   output logic [47:0] lst_inv_addr,
   output logic [1:0]  lst_inv_port
);

   chk_state_t              state;
   chk_state_t              nxt_state;
   logic [`ALUT_HASH_W-1:0] d_hash;
   logic [`ALUT_HASH_W-1:0] s_hash;
   logic                    dest_miss;   // sticky through the lookup
   logic                    src_clash;
   port_mask_t              flood_mask;

   function automatic logic [`ALUT_HASH_W-1:0] addr_hash(input logic [47:0] a);
      return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ a[39:32] ^ a[47:40];
   endfunction

   function automatic port_mask_t port_bit(input logic [1:0] p);
      return port_mask_t'(5'b0_0001 << p);
   endfunction

   assign d_hash     = addr_hash(d_addr);
   assign s_hash     = addr_hash(s_addr);
   assign flood_mask = 5'b0_1111 & ~port_bit(s_port);   // never back out the source

   // ------------------------------------------------------------
   // lookup and learn FSM
   // ------------------------------------------------------------
   always_comb
   begin
      nxt_state = state;
      case (state)
         idle:         if (command == `ALUT_CMD_CHECK) nxt_state = mac_addr_chk;
         mac_addr_chk: nxt_state = (d_addr == mac_addr) ? idle : read_dest;
         read_dest:    nxt_state = valid_chk;
         valid_chk:    nxt_state = age_chk;
         age_chk:      if (age_confirmed) nxt_state = addr_chk;   // two cycles here
         addr_chk:     nxt_state = read_src;
         read_src:     nxt_state = write_src;
         write_src:    nxt_state = idle;
         default:      nxt_state = idle;
      endcase
   end

   always_ff @(posedge pclk23 or negedge n_p_reset23)
   begin
      if (!n_p_reset23)
         state <= idle;
      else
         state <= nxt_state;
   end

   assign add_check_active = (state != idle);   // status bit 0

   // ------------------------------------------------------------
   // table access
   // ------------------------------------------------------------
   // destination slot until the lookup is done, then the source slot
   assign mem.addr     = (state == read_src || state == write_src) ? s_hash : d_hash;
   assign mem.we       = (state == write_src);
   assign mem.wr_entry = '{valid: 1'b1, last_time: curr_time, port: s_port, addr: s_addr};

   // age request carries the time stamp read in valid_chk
   always_ff @(posedge pclk23 or negedge n_p_reset23)
   begin
      if (!n_p_reset23)
      begin
         check_age     <= 1'b0;
         last_accessed <= '0;
      end
      else
      begin
         check_age <= (state == valid_chk);
         if (state == valid_chk)
            last_accessed <= mem.rd_entry.last_time;
      end
   end

   // empty or stale slot means the destination is unknown
   always_ff @(posedge pclk23 or negedge n_p_reset23)
   begin
      if (!n_p_reset23)
         dest_miss <= 1'b0;
      else if (state == valid_chk)
         dest_miss <= !mem.rd_entry.valid;
      else if (state == age_chk && age_confirmed && !age_ok)
         dest_miss <= 1'b1;
   end

   // ------------------------------------------------------------
   // destination port mask
   // ------------------------------------------------------------
   always_ff @(posedge pclk23 or negedge n_p_reset23)
   begin
      if (!n_p_reset23)
         d_port <= 5'b0_1111;
      else if (state == mac_addr_chk && d_addr == mac_addr)
         d_port <= 5'b1_0000;                     // frame for the switch itself
      else if (state == addr_chk)
      begin
         if (dest_miss || mem.rd_entry.addr != d_addr)
            d_port <= flood_mask;                 // hash hit on another address
         else
            d_port <= port_bit(mem.rd_entry.port) & ~port_bit(s_port);
      end
   end

   // ------------------------------------------------------------
   // reuse tracking, source slot was read in read_src
   // ------------------------------------------------------------
   assign src_clash = (state == write_src) && mem.rd_entry.valid &&
                      (mem.rd_entry.addr != s_addr);

   always_ff @(posedge pclk23 or negedge n_p_reset23)
   begin
      if (!n_p_reset23)
      begin
         reused       <= 1'b0;
         lst_inv_addr <= '0;
         lst_inv_port <= '0;
      end
      else if (src_clash)
      begin
         reused       <= 1'b1;                    // set wins over the clear
         lst_inv_addr <= mem.rd_entry.addr;
         lst_inv_port <= mem.rd_entry.port;
      end
      else if (clear_reused)
         reused <= 1'b0;
   end

   // switch and ethernet ports are never both targeted
   a_dport_exclusive: assert property (@(posedge pclk23) disable iff (!n_p_reset23)
      !(d_port[4] && (|d_port[3:0])));

   // learning only ever overwrites a slot that was checked the cycle before
   a_write_after_src_read: assert property (@(posedge pclk23) disable iff (!n_p_reset23)
      mem.we |-> (state == write_src) && ($past(mem.addr) == mem.addr));

endmodule

`default_nettype wire

// ==== design/alut_age_checker.sv ====
`default_nettype none

module alut_age_checker
(
   input  logic        pclk23,
   input  logic        n_p_reset23,
   input  logic [31:0] age_limit,       // max age in clocks
   input  logic        check_age,       // one-cycle request
   input  logic [31:0] last_accessed,   // time stamp of the entry under test
   output logic [31:0] curr_time,
   output logic        age_confirmed,   // reply, one cycle after request
   output logic        age_ok           // entry still fresh
);

   logic [31:0] age_delta;

   assign age_delta = curr_time - last_accessed;   // wraps with the counter

   // ------------------------------------------------------------
   // free-running time base
   // ------------------------------------------------------------
   always_ff @(posedge pclk23 or negedge n_p_reset23)
   begin
      if (!n_p_reset23)
         curr_time <= '0;
      else
         curr_time <= curr_time + 32'd1;
   end

   // ------------------------------------------------------------
   // single request, reply on the next edge
   // ------------------------------------------------------------
   always_ff @(posedge pclk23 or negedge n_p_reset23)
   begin
      if (!n_p_reset23)
      begin
         age_confirmed <= 1'b0;
         age_ok        <= 1'b0;
      end
      else
      begin
         age_confirmed <= check_age;
         age_ok        <= check_age && (age_delta <= age_limit);   // only valid with confirm
      end
   end

   // checker relies on exactly one reply per request
   a_reply_follows_req: assert property (@(posedge pclk23) disable iff (!n_p_reset23)
      age_confirmed |-> $past(check_age));

endmodule

`default_nettype wire

// ==== design/alut_mem.sv ====
`default_nettype none

`include "alut_macros.svh"

module alut_mem
   import alut_pkg::*;
(
   input  logic   pclk23,
   input  logic   n_p_reset23,
   alut_mem_if.tbl mem
);

   alut_entry_t             entries [`ALUT_DEPTH];  // addr, port and time per slot
   logic [`ALUT_DEPTH-1:0]  valid_q;                // cleared by reset, unlike entries
   alut_entry_t             rd_word;

   // valid flags live apart so a reset empties the whole table at once
   always_ff @(posedge pclk23 or negedge n_p_reset23)
   begin
      if (!n_p_reset23)
         valid_q <= '0;
      else if (mem.we)
         valid_q[mem.addr] <= 1'b1;   // every write learns a live entry
   end

   always_ff @(posedge pclk23)
   begin
      if (mem.we)
         entries[mem.addr] <= mem.wr_entry;
   end

   // stored word with its valid flag taken from the vector
   always_comb
   begin
      rd_word       = entries[mem.addr];
      rd_word.valid = valid_q[mem.addr];
   end

   always_ff @(posedge pclk23)
   begin
      mem.rd_entry <= rd_word;        // read before write on a collision
   end

endmodule

`default_nettype wire

// ==== design/alut_mem_if.sv ====
`default_nettype none

`include "alut_macros.svh"

interface alut_mem_if import alut_pkg::*; ();

   logic [`ALUT_HASH_W-1:0] addr;       // slot index
   logic                    we;         // write at this edge
   alut_entry_t             wr_entry;
   alut_entry_t             rd_entry;   // registered, one cycle after addr

   modport chk (output addr, output we, output wr_entry, input rd_entry);

   modport tbl (input addr, input we, input wr_entry, output rd_entry);

endinterface

`default_nettype wire

// ==== design/alut_pkg.sv ====
`default_nettype none

package alut_pkg;

   // one table slot, valid on top
   typedef struct packed {
      logic        valid;      // slot holds a learned address
      logic [31:0] last_time;  // time stamp of the last learn
      logic [1:0]  port;       // ethernet port the address came in on
      logic [47:0] addr;       // learned source address
   } alut_entry_t;

   // bits 3..0 are the ethernet ports, bit 4 the switch itself
   typedef logic [4:0] port_mask_t;

   // address checker states, in walk order
   typedef enum logic [2:0] {
      idle         = 3'd0,
      mac_addr_chk = 3'd1,   // destination against the switch address
      read_dest    = 3'd2,   // present destination hash to the table
      valid_chk    = 3'd3,
      age_chk      = 3'd4,   // request and reply with the age checker
      addr_chk     = 3'd5,
      read_src     = 3'd6,   // read the slot about to be overwritten
      write_src    = 3'd7
   } chk_state_t;

endpackage

`default_nettype wire

// ==== include/alut_macros.svh ====
`ifndef ALUT_MACROS_SVH
`define ALUT_MACROS_SVH

// table geometry
`define ALUT_HASH_W        8       // xor of the six address bytes
`define ALUT_DEPTH         256     // one slot per hash value

// command codes written to CMD
`define ALUT_CMD_CHECK     2'd1    // look up d_addr and learn s_addr

// wishbone word offsets
`define ALUT_REG_MAC_LO    4'd0    // switch address bits 31..0
`define ALUT_REG_MAC_HI    4'd1    // switch address bits 47..32
`define ALUT_REG_DADDR_LO  4'd2
`define ALUT_REG_DADDR_HI  4'd3
`define ALUT_REG_SADDR_LO  4'd4
`define ALUT_REG_SADDR_HI  4'd5
`define ALUT_REG_SPORT     4'd6    // source port in bits 1..0
`define ALUT_REG_CMD       4'd7
`define ALUT_REG_AGE_LIMIT 4'd8
`define ALUT_REG_STATUS    4'd9    // read clears the reused flag
`define ALUT_REG_INV_LO    4'd10
`define ALUT_REG_INV_HI    4'd11   // port sits in bits 17..16

// entries older than this many clocks count as stale
`define ALUT_AGE_DEFAULT   32'd10000

`endif
